// ==== verilog/lsq_pkg.sv ====
package lsq_pkg;

	// ==========================================================
	// Queue and memory geometry
	// ==========================================================

	localparam int LSQ_ENTRIES = 8;
	localparam int LSQ_NDX_W = 3;
	localparam int MEM_WORDS = 256;
	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;

	// An entry index doubles as the tag handed back on enqueue
	typedef logic [LSQ_NDX_W-1:0] lsq_ndx_t;
	typedef logic [7:0] seqnum_t;
	// Distance of an entry from the head, zero being the oldest
	typedef logic [LSQ_NDX_W-1:0] age_t;
	typedef logic [ADDR_W-1:0] word_addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [DATA_W/8-1:0] byte_en_t;
	typedef logic [1:0] memsz_t;

	// Access sizes, data always sits in the low byte lanes
	localparam memsz_t MEMSZ_BYTE = 2'd0;
	localparam memsz_t MEMSZ_HALF = 2'd1;
	localparam memsz_t MEMSZ_WORD = 2'd2;

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		RETIRE
	} drain_state_t;

	// ==========================================================
	// Size helpers
	// ==========================================================

	// Byte lanes touched by an access of the given size
	function automatic byte_en_t size_be(memsz_t sz);
		case (sz)
			MEMSZ_BYTE: size_be = 4'b0001;
			MEMSZ_HALF: size_be = 4'b0011;
			MEMSZ_WORD: size_be = 4'b1111;
			default:    size_be = 4'b0000;
		endcase
	endfunction

	// Bit mask that zero-extends a load of the given size
	function automatic data_t size_mask(memsz_t sz);
		byte_en_t be;
		be = size_be(sz);
		for (int b = 0; b < DATA_W/8; b++) begin
			size_mask[b*8 +: 8] = {8{be[b]}};
		end
	endfunction

endpackage

// ==== verilog/lsq_bypass_index.sv ====
`timescale 1ns/1ps

module lsq_bypass_index (
	input  logic [lsq_pkg::LSQ_ENTRIES-1:0] ent_valid_i,
	input  logic [lsq_pkg::LSQ_ENTRIES-1:0] ent_load_i,
	input  logic [lsq_pkg::LSQ_ENTRIES-1:0] ent_datav_i,
	input  lsq_pkg::memsz_t                 ent_size_i [lsq_pkg::LSQ_ENTRIES],
	input  lsq_pkg::word_addr_t             ent_addr_i [lsq_pkg::LSQ_ENTRIES],
	input  lsq_pkg::age_t                   ent_age_i  [lsq_pkg::LSQ_ENTRIES],
	input  lsq_pkg::lsq_ndx_t               ld_ndx_i,
	output logic                            hit_o,
	output lsq_pkg::lsq_ndx_t               fwd_ndx_o,
	output logic                            blocked_o
);
	import lsq_pkg::*;

	logic found;
	age_t best_age;
	logic ld_ok;

	// Find the youngest store that is older than the load and touches the same word.
	// Size and data validity are checked afterwards, because a younger store that
	// cannot forward hides every older one behind it
	always_comb begin
		found = 1'b0;
		best_age = '0;
		fwd_ndx_o = '0;
		for (int i = 0; i < LSQ_ENTRIES; i++) begin
			if (ent_valid_i[i] && !ent_load_i[i] &&
			    ent_age_i[i] < ent_age_i[ld_ndx_i] &&
			    ent_addr_i[i] == ent_addr_i[ld_ndx_i] &&
			    (!found || ent_age_i[i] > best_age)) begin
				found = 1'b1;
				best_age = ent_age_i[i];
				fwd_ndx_o = lsq_ndx_t'(i);
			end
		end
	end

	// The answer only means something when the chosen entry is a live load
	assign ld_ok = ent_valid_i[ld_ndx_i] && ent_load_i[ld_ndx_i];

	// Forward only from an exact size match whose data has arrived
	assign hit_o = ld_ok && found && ent_datav_i[fwd_ndx_o] &&
	               ent_size_i[fwd_ndx_o] == ent_size_i[ld_ndx_i];

	// Otherwise the load has to wait for that store to drain or get its data
	assign blocked_o = ld_ok && found && !hit_o;

endmodule

// ==== verilog/lsq_queue.sv ====
`timescale 1ns/1ps

module lsq_queue (
	input  logic                            clk_i,
	input  logic                            arst_n_i,
	input  logic                            enq_valid_i,
	input  logic                            enq_load_i,
	input  lsq_pkg::memsz_t                 enq_size_i,
	input  lsq_pkg::word_addr_t             enq_addr_i,
	output lsq_pkg::lsq_ndx_t               enq_tag_o,
	output logic                            full_o,
	input  logic                            sdata_valid_i,
	input  lsq_pkg::lsq_ndx_t               sdata_tag_i,
	input  lsq_pkg::data_t                  sdata_i,
	input  logic                            ld_complete_i,
	input  lsq_pkg::lsq_ndx_t               ld_complete_tag_i,
	input  logic                            store_retire_i,
	output lsq_pkg::lsq_ndx_t               head_ndx_o,
	output logic [lsq_pkg::LSQ_ENTRIES-1:0] ent_valid_o,
	output logic [lsq_pkg::LSQ_ENTRIES-1:0] ent_load_o,
	output logic [lsq_pkg::LSQ_ENTRIES-1:0] ent_datav_o,
	output lsq_pkg::memsz_t                 ent_size_o [lsq_pkg::LSQ_ENTRIES],
	output lsq_pkg::word_addr_t             ent_addr_o [lsq_pkg::LSQ_ENTRIES],
	output lsq_pkg::data_t                  ent_data_o [lsq_pkg::LSQ_ENTRIES],
	output lsq_pkg::age_t                   ent_age_o  [lsq_pkg::LSQ_ENTRIES]
);
	import lsq_pkg::*;

	lsq_ndx_t tail;
	logic [LSQ_NDX_W:0] count;
	seqnum_t next_sn;
	seqnum_t ent_sn [LSQ_ENTRIES];
	logic [LSQ_ENTRIES-1:0] ent_done;
	logic accept;
	logic retire;

	assign full_o = count == (LSQ_NDX_W+1)'(LSQ_ENTRIES);
	assign accept = enq_valid_i && !full_o;
	assign enq_tag_o = tail;

	// A load at the head leaves once it has completed, a store on the drain strobe
	assign retire = ent_valid_o[head_ndx_o] &&
	                (ent_load_o[head_ndx_o] ? ent_done[head_ndx_o] : store_retire_i);

	// Sequence numbers are handed out in program order, so the wrapped
	// difference to the head number is the distance from the head
	always_comb begin
		for (int i = 0; i < LSQ_ENTRIES; i++) begin
			ent_age_o[i] = age_t'(ent_sn[i] - ent_sn[head_ndx_o]);
		end
	end

	// ==========================================================
	// Pointers and per-entry status
	// ==========================================================

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			head_ndx_o <= '0;
			tail <= '0;
			count <= '0;
			next_sn <= '0;
			ent_valid_o <= '0;
			ent_done <= '0;
			ent_datav_o <= '0;
		end else begin
			if (accept) begin
				tail <= tail + 1'b1;
				next_sn <= next_sn + 1'b1;
				ent_valid_o[tail] <= 1'b1;
				ent_done[tail] <= 1'b0;
				ent_datav_o[tail] <= 1'b0;
			end
			// Store data is written by tag and may come any time after the enqueue
			if (sdata_valid_i) begin
				ent_datav_o[sdata_tag_i] <= 1'b1;
			end
			if (ld_complete_i) begin
				ent_done[ld_complete_tag_i] <= 1'b1;
			end
			// Entry is free from this edge on
			if (retire) begin
				head_ndx_o <= head_ndx_o + 1'b1;
				ent_valid_o[head_ndx_o] <= 1'b0;
			end
			count <= count + (LSQ_NDX_W+1)'(accept) - (LSQ_NDX_W+1)'(retire);
		end
	end

	// Payload fields are only read while the valid bit is set
	always_ff @(posedge clk_i) begin
		if (accept) begin
			ent_load_o[tail] <= enq_load_i;
			ent_size_o[tail] <= enq_size_i;
			ent_addr_o[tail] <= enq_addr_i;
			ent_sn[tail] <= next_sn;
		end
		if (sdata_valid_i) begin
			ent_data_o[sdata_tag_i] <= sdata_i;
		end
	end

endmodule

// ==== verilog/lsq_load_issue.sv ====
`timescale 1ns/1ps

module lsq_load_issue (
	input  logic                            clk_i,
	input  logic                            arst_n_i,
	input  logic [lsq_pkg::LSQ_ENTRIES-1:0] ent_valid_i,
	input  logic [lsq_pkg::LSQ_ENTRIES-1:0] ent_load_i,
	input  lsq_pkg::memsz_t                 ent_size_i [lsq_pkg::LSQ_ENTRIES],
	input  lsq_pkg::word_addr_t             ent_addr_i [lsq_pkg::LSQ_ENTRIES],
	input  lsq_pkg::data_t                  ent_data_i [lsq_pkg::LSQ_ENTRIES],
	input  lsq_pkg::age_t                   ent_age_i  [lsq_pkg::LSQ_ENTRIES],
	input  logic                            hit_i,
	input  lsq_pkg::lsq_ndx_t               fwd_ndx_i,
	input  logic                            blocked_i,
	output lsq_pkg::lsq_ndx_t               ld_ndx_o,
	output logic                            mem_req_o,
	output lsq_pkg::word_addr_t             mem_addr_o,
	input  logic                            mem_gnt_i,
	input  lsq_pkg::data_t                  mem_rdata_i,
	output logic                            ld_done_o,
	output lsq_pkg::lsq_ndx_t               ld_tag_o,
	output lsq_pkg::data_t                  ld_data_o
);
	import lsq_pkg::*;

	logic [LSQ_ENTRIES-1:0] issued;
	logic cand_found;
	age_t cand_age;
	logic rd_pend;
	lsq_ndx_t rd_tag;
	memsz_t rd_size;
	logic do_fwd;
	logic do_read;

	// The oldest live load that has not gone out yet is offered to the bypass block
	always_comb begin
		cand_found = 1'b0;
		cand_age = '0;
		ld_ndx_o = '0;
		for (int i = 0; i < LSQ_ENTRIES; i++) begin
			if (ent_valid_i[i] && ent_load_i[i] && !issued[i] &&
			    (!cand_found || ent_age_i[i] < cand_age)) begin
				cand_found = 1'b1;
				cand_age = ent_age_i[i];
				ld_ndx_o = lsq_ndx_t'(i);
			end
		end
	end

	// Returning read data owns the result port, so forwarding skips that cycle.
	// Only one memory read is in flight at a time
	assign do_fwd = cand_found && !blocked_i && hit_i && !rd_pend;
	assign do_read = cand_found && !blocked_i && !hit_i && !mem_req_o && !rd_pend;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			issued <= '0;
			mem_req_o <= 1'b0;
			rd_pend <= 1'b0;
			ld_done_o <= 1'b0;
		end else begin
			// A freed entry forgets that its load went out
			for (int i = 0; i < LSQ_ENTRIES; i++) begin
				if (!ent_valid_i[i]) begin
					issued[i] <= 1'b0;
				end
			end
			if (do_fwd || do_read) begin
				issued[ld_ndx_o] <= 1'b1;
			end
			// Request is held until the arbiter grants it
			if (do_read) begin
				mem_req_o <= 1'b1;
			end else if (mem_gnt_i) begin
				mem_req_o <= 1'b0;
			end
			// Memory answers in the cycle after the grant
			rd_pend <= mem_req_o && mem_gnt_i;
			ld_done_o <= do_fwd || rd_pend;
		end
	end

	always_ff @(posedge clk_i) begin
		if (do_read) begin
			rd_tag <= ld_ndx_o;
			rd_size <= ent_size_i[ld_ndx_o];
			mem_addr_o <= ent_addr_i[ld_ndx_o];
		end
		if (rd_pend) begin
			ld_tag_o <= rd_tag;
			ld_data_o <= mem_rdata_i & size_mask(rd_size);
		end else if (do_fwd) begin
			ld_tag_o <= ld_ndx_o;
			ld_data_o <= ent_data_i[fwd_ndx_i] & size_mask(ent_size_i[ld_ndx_o]);
		end
	end

endmodule

// ==== verilog/lsq_store_drain.sv ====
`timescale 1ns/1ps

module lsq_store_drain (
	input  logic                            clk_i,
	input  logic                            arst_n_i,
	input  logic [lsq_pkg::LSQ_ENTRIES-1:0] ent_valid_i,
	input  logic [lsq_pkg::LSQ_ENTRIES-1:0] ent_load_i,
	input  logic [lsq_pkg::LSQ_ENTRIES-1:0] ent_datav_i,
	input  lsq_pkg::memsz_t                 ent_size_i [lsq_pkg::LSQ_ENTRIES],
	input  lsq_pkg::word_addr_t             ent_addr_i [lsq_pkg::LSQ_ENTRIES],
	input  lsq_pkg::data_t                  ent_data_i [lsq_pkg::LSQ_ENTRIES],
	input  lsq_pkg::lsq_ndx_t               head_ndx_i,
	output logic                            mem_req_o,
	input  logic                            mem_gnt_i,
	output lsq_pkg::word_addr_t             mem_addr_o,
	output lsq_pkg::byte_en_t               mem_be_o,
	output lsq_pkg::data_t                  mem_wdata_o,
	output logic                            retire_o
);
	import lsq_pkg::*;

	drain_state_t state;
	drain_state_t state_nxt;
	logic head_ready;

	// Stores leave strictly from the head and only once their data is in
	assign head_ready = ent_valid_i[head_ndx_i] && !ent_load_i[head_ndx_i] &&
	                    ent_datav_i[head_ndx_i];

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:    if (head_ready) state_nxt = REQ;
			// Memory is written in the grant cycle
			REQ:     if (mem_gnt_i) state_nxt = RETIRE;
			RETIRE:  state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	assign mem_req_o = state == REQ;
	assign retire_o = state == RETIRE;

	// Write port fields come straight from the head entry
	assign mem_addr_o = ent_addr_i[head_ndx_i];
	assign mem_be_o = size_be(ent_size_i[head_ndx_i]);
	assign mem_wdata_o = ent_data_i[head_ndx_i];

endmodule

// ==== verilog/lsq_mem_arbiter.sv ====
`timescale 1ns/1ps

module lsq_mem_arbiter (
	input  logic                clk_i,
	input  logic                arst_n_i,
	input  logic                ld_req_i,
	input  lsq_pkg::word_addr_t ld_addr_i,
	input  logic                st_req_i,
	input  lsq_pkg::word_addr_t st_addr_i,
	input  lsq_pkg::byte_en_t   st_be_i,
	input  lsq_pkg::data_t      st_wdata_i,
	output logic                ld_gnt_o,
	output logic                st_gnt_o,
	output logic                mem_en_o,
	output logic                mem_we_o,
	output lsq_pkg::word_addr_t mem_addr_o,
	output lsq_pkg::byte_en_t   mem_be_o,
	output lsq_pkg::data_t      mem_wdata_o
);
	import lsq_pkg::*;

	// Set when the store side won the most recent grant
	logic last_st;

	// Under contention the peer that did not win last time goes first
	assign ld_gnt_o = ld_req_i && (!st_req_i || last_st);
	assign st_gnt_o = st_req_i && !ld_gnt_o;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			last_st <= 1'b0;
		end else if (ld_gnt_o || st_gnt_o) begin
			last_st <= st_gnt_o;
		end
	end

	// Reads use the whole word, the load side extracts its lanes
	assign mem_en_o = ld_gnt_o || st_gnt_o;
	assign mem_we_o = st_gnt_o;
	assign mem_addr_o = st_gnt_o ? st_addr_i : ld_addr_i;
	assign mem_be_o = st_gnt_o ? st_be_i : byte_en_t'('1);
	assign mem_wdata_o = st_gnt_o ? st_wdata_i : data_t'('0);

endmodule

// ==== verilog/lsq_data_mem.sv ====
`timescale 1ns/1ps

module lsq_data_mem (
	input  logic                clk_i,
	input  logic                en_i,
	input  logic                we_i,
	input  lsq_pkg::word_addr_t addr_i,
	input  lsq_pkg::byte_en_t   be_i,
	input  lsq_pkg::data_t      wdata_i,
	output lsq_pkg::data_t      rdata_o
);
	import lsq_pkg::*;

	data_t mem [MEM_WORDS];

	initial begin
		for (int w = 0; w < MEM_WORDS; w++) begin
			mem[w] = '0;
		end
	end

	// Only the enabled byte lanes change on a write
	always @(posedge clk_i) begin
		if (en_i && we_i) begin
			for (int b = 0; b < DATA_W/8; b++) begin
				if (be_i[b]) begin
					mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
				end
			end
		end
	end

	// Read data holds until the next read
	always_ff @(posedge clk_i) begin
		if (en_i && !we_i) begin
			rdata_o <= mem[addr_i];
		end
	end

endmodule

// ==== verilog/lsq_top.sv ====
`timescale 1ns/1ps

module lsq_top (
	input  logic                clk_i,
	input  logic                arst_n_i,
	input  logic                enq_valid_i,
	input  logic                enq_load_i,
	input  lsq_pkg::memsz_t     enq_size_i,
	input  lsq_pkg::word_addr_t enq_addr_i,
	input  logic                sdata_valid_i,
	input  lsq_pkg::lsq_ndx_t   sdata_tag_i,
	input  lsq_pkg::data_t      sdata_i,
	output logic                full_o,
	output lsq_pkg::lsq_ndx_t   enq_tag_o,
	output logic                ld_done_o,
	output lsq_pkg::lsq_ndx_t   ld_tag_o,
	output lsq_pkg::data_t      ld_data_o
);
	import lsq_pkg::*;

	// ==========================================================
	// Entry vectors shared by the queue and its readers
	// ==========================================================

	logic [LSQ_ENTRIES-1:0] ent_valid;
	logic [LSQ_ENTRIES-1:0] ent_load;
	logic [LSQ_ENTRIES-1:0] ent_datav;
	memsz_t ent_size [LSQ_ENTRIES];
	word_addr_t ent_addr [LSQ_ENTRIES];
	data_t ent_data [LSQ_ENTRIES];
	age_t ent_age [LSQ_ENTRIES];
	lsq_ndx_t head_ndx;

	// Bypass query and answer
	lsq_ndx_t ld_ndx;
	logic hit;
	lsq_ndx_t fwd_ndx;
	logic blocked;

	// Memory port peers
	logic ld_req;
	logic ld_gnt;
	word_addr_t ld_addr;
	logic st_req;
	logic st_gnt;
	word_addr_t st_addr;
	byte_en_t st_be;
	data_t st_wdata;
	logic st_retire;

	logic mem_en;
	logic mem_we;
	word_addr_t mem_addr;
	byte_en_t mem_be;
	data_t mem_wdata;
	data_t mem_rdata;

	// Load results also mark the entry complete for retirement
	lsq_queue u_queue (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.enq_valid_i(enq_valid_i), .enq_load_i(enq_load_i),
		.enq_size_i(enq_size_i), .enq_addr_i(enq_addr_i),
		.enq_tag_o(enq_tag_o), .full_o(full_o),
		.sdata_valid_i(sdata_valid_i), .sdata_tag_i(sdata_tag_i), .sdata_i(sdata_i),
		.ld_complete_i(ld_done_o), .ld_complete_tag_i(ld_tag_o),
		.store_retire_i(st_retire), .head_ndx_o(head_ndx),
		.ent_valid_o(ent_valid), .ent_load_o(ent_load), .ent_datav_o(ent_datav),
		.ent_size_o(ent_size), .ent_addr_o(ent_addr), .ent_data_o(ent_data),
		.ent_age_o(ent_age)
	);

	lsq_bypass_index u_bypass (
		.ent_valid_i(ent_valid), .ent_load_i(ent_load), .ent_datav_i(ent_datav),
		.ent_size_i(ent_size), .ent_addr_i(ent_addr), .ent_age_i(ent_age),
		.ld_ndx_i(ld_ndx), .hit_o(hit), .fwd_ndx_o(fwd_ndx), .blocked_o(blocked)
	);

	lsq_load_issue u_load_issue (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.ent_valid_i(ent_valid), .ent_load_i(ent_load), .ent_size_i(ent_size),
		.ent_addr_i(ent_addr), .ent_data_i(ent_data), .ent_age_i(ent_age),
		.hit_i(hit), .fwd_ndx_i(fwd_ndx), .blocked_i(blocked), .ld_ndx_o(ld_ndx),
		.mem_req_o(ld_req), .mem_addr_o(ld_addr), .mem_gnt_i(ld_gnt),
		.mem_rdata_i(mem_rdata),
		.ld_done_o(ld_done_o), .ld_tag_o(ld_tag_o), .ld_data_o(ld_data_o)
	);

	lsq_store_drain u_store_drain (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.ent_valid_i(ent_valid), .ent_load_i(ent_load), .ent_datav_i(ent_datav),
		.ent_size_i(ent_size), .ent_addr_i(ent_addr), .ent_data_i(ent_data),
		.head_ndx_i(head_ndx), .mem_req_o(st_req), .mem_gnt_i(st_gnt),
		.mem_addr_o(st_addr), .mem_be_o(st_be), .mem_wdata_o(st_wdata),
		.retire_o(st_retire)
	);

	lsq_mem_arbiter u_arbiter (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.ld_req_i(ld_req), .ld_addr_i(ld_addr),
		.st_req_i(st_req), .st_addr_i(st_addr), .st_be_i(st_be), .st_wdata_i(st_wdata),
		.ld_gnt_o(ld_gnt), .st_gnt_o(st_gnt),
		.mem_en_o(mem_en), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
		.mem_be_o(mem_be), .mem_wdata_o(mem_wdata)
	);

	lsq_data_mem u_data_mem (
		.clk_i(clk_i), .en_i(mem_en), .we_i(mem_we), .addr_i(mem_addr),
		.be_i(mem_be), .wdata_i(mem_wdata), .rdata_o(mem_rdata)
	);

endmodule

// ==== dv/lsq_sva.sv ====
`timescale 1ns/1ps

module lsq_sva (
	input  logic                            clk_i,
	input  logic                            arst_n_i,
	input  logic                            ld_req_i,
	input  logic                            st_req_i,
	input  logic                            ld_gnt_i,
	input  logic                            st_gnt_i,
	input  logic                            full_i,
	input  logic                            enq_valid_i,
	input  lsq_pkg::lsq_ndx_t               enq_tag_i,
	input  logic                            ld_complete_i,
	input  lsq_pkg::lsq_ndx_t               ld_complete_tag_i,
	input  logic [lsq_pkg::LSQ_ENTRIES-1:0] ent_valid_i
);

	// Number of failed assertions in this instance
	int fail_cnt = 0;

	// Round robin lets a load that lost one cycle win the next one
	a_ld_served: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		ld_req_i && !ld_gnt_i |=> ld_gnt_i)
		else begin
			$error("Load request lost arbitration twice in a row");
			fail_cnt++;
		end

	// The same holds for a waiting store
	a_st_served: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		st_req_i && !st_gnt_i |=> st_gnt_i)
		else begin
			$error("Store request lost arbitration twice in a row");
			fail_cnt++;
		end

	// An accepted enqueue always lands on a free entry
	a_enq_to_free: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		enq_valid_i && !full_i |-> !ent_valid_i[enq_tag_i])
		else begin
			$error("Enqueue accepted into an entry that is still valid");
			fail_cnt++;
		end

	// A result has to belong to a live entry, it retires at the earliest one edge later
	a_done_on_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		ld_complete_i |-> ent_valid_i[ld_complete_tag_i])
		else begin
			$error("Load completion for an entry that is not valid");
			fail_cnt++;
		end

endmodule

// ==== dv/lsq_checker.sv ====
`timescale 1ns/1ps

module lsq_checker (
	input  logic                clk_i,
	input  logic                arst_n_i,
	input  logic                enq_valid_i,
	input  logic                enq_load_i,
	input  lsq_pkg::memsz_t     enq_size_i,
	input  lsq_pkg::word_addr_t enq_addr_i,
	input  lsq_pkg::lsq_ndx_t   enq_tag_i,
	input  logic                full_i,
	input  lsq_pkg::data_t      enq_exp_i,
	input  logic                sdata_valid_i,
	input  lsq_pkg::lsq_ndx_t   sdata_tag_i,
	input  lsq_pkg::data_t      sdata_i,
	input  logic                ld_done_i,
	input  lsq_pkg::lsq_ndx_t   ld_tag_i,
	input  lsq_pkg::data_t      ld_data_i,
	output int                  err_cnt_o,
	output int                  done_cnt_o,
	output int                  pending_o
);
	import lsq_pkg::*;

	localparam int HIST_MAX = 256;

	// ==========================================================
	// Program-order history of every accepted operation
	// ==========================================================

	logic hist_load [HIST_MAX];
	memsz_t hist_size [HIST_MAX];
	word_addr_t hist_addr [HIST_MAX];
	data_t hist_data [HIST_MAX];
	logic hist_datav [HIST_MAX];
	data_t hist_exp [HIST_MAX];
	int hist_n;
	// Tag to history position of the operation that holds the entry now
	int tag_hist [LSQ_ENTRIES];
	logic [LSQ_ENTRIES-1:0] ld_open;
	int idx;
	data_t model_val;
	bit missing;

	function automatic int lane_count(memsz_t sz);
		case (sz)
			2'd0: return 1;
			2'd1: return 2;
			2'd2: return 4;
			default: return 0;
		endcase
	endfunction

	// A load sees zero-initialised memory with every older store to its word applied in order
	function automatic data_t model_value(int pos, output bit data_missing);
		data_t v;
		v = '0;
		data_missing = 1'b0;
		for (int j = 0; j < pos; j++) begin
			if (!hist_load[j] && hist_addr[j] == hist_addr[pos]) begin
				if (!hist_datav[j]) begin
					data_missing = 1'b1;
				end
				for (int b = 0; b < lane_count(hist_size[j]); b++) begin
					v[b*8 +: 8] = hist_data[j][b*8 +: 8];
				end
			end
		end
		// Zero extension above the load's own lanes
		for (int b = lane_count(hist_size[pos]); b < 4; b++) begin
			v[b*8 +: 8] = 8'h00;
		end
		return v;
	endfunction

	// Sampled on the falling edge, where inputs and registered outputs are settled
	always @(negedge clk_i) begin
		if (!arst_n_i) begin
			hist_n = 0;
			ld_open = '0;
			err_cnt_o = 0;
			done_cnt_o = 0;
			pending_o = 0;
			for (int t = 0; t < LSQ_ENTRIES; t++) begin
				tag_hist[t] = 0;
			end
		end else begin
			if (ld_done_i) begin
				idx = tag_hist[ld_tag_i];
				if (!ld_open[ld_tag_i]) begin
					$display("FAILED at %0t: completion for tag %0d with no open load",
					         $time, ld_tag_i);
					err_cnt_o++;
				end else begin
					model_val = model_value(idx, missing);
					ld_open[ld_tag_i] = 1'b0;
					done_cnt_o++;
					pending_o--;
					if (missing) begin
						$display("FAILED at %0t: load tag %0d done before older store data",
						         $time, ld_tag_i);
						err_cnt_o++;
					end else if (ld_data_i !== model_val) begin
						$display("FAILED at %0t: load tag %0d addr %h got %h, expected %h",
						         $time, ld_tag_i, hist_addr[idx], ld_data_i, model_val);
						err_cnt_o++;
					end
					if (hist_exp[idx] !== model_val) begin
						$display("FAILED at %0t: pattern expects %h at addr %h, model gives %h",
						         $time, hist_exp[idx], hist_addr[idx], model_val);
						err_cnt_o++;
					end
				end
			end
			// Enqueue first so that a store carrying its data in the same cycle finds its slot
			if (enq_valid_i && !full_i) begin
				if (hist_n < HIST_MAX) begin
					// Entries are handed out in ring order starting at entry zero after reset
					if (enq_tag_i !== lsq_ndx_t'(hist_n)) begin
						$display("FAILED at %0t: enqueue got tag %0d, expected %0d",
						         $time, enq_tag_i, lsq_ndx_t'(hist_n));
						err_cnt_o++;
					end
					hist_load[hist_n] = enq_load_i;
					hist_size[hist_n] = enq_size_i;
					hist_addr[hist_n] = enq_addr_i;
					hist_datav[hist_n] = 1'b0;
					hist_exp[hist_n] = enq_exp_i;
					tag_hist[enq_tag_i] = hist_n;
					hist_n++;
					if (enq_load_i) begin
						ld_open[enq_tag_i] = 1'b1;
						pending_o++;
					end
				end else begin
					$display("Checker history is full, operation not tracked");
					err_cnt_o++;
				end
			end
			if (sdata_valid_i) begin
				hist_data[tag_hist[sdata_tag_i]] = sdata_i;
				hist_datav[tag_hist[sdata_tag_i]] = 1'b1;
			end
		end
	end

endmodule

// ==== dv/lsq_tb.sv ====
`timescale 1ns/1ps

module lsq_tb;
	import lsq_pkg::*;

	localparam int PAT_WORDS = 256;
	localparam int FULL_LIMIT = 200;
	localparam int DRAIN_LIMIT = 2000;

	logic clk;
	logic arst_n;
	logic enq_valid;
	logic enq_load;
	memsz_t enq_size;
	word_addr_t enq_addr;
	lsq_ndx_t enq_tag;
	logic full;
	logic sdata_valid;
	lsq_ndx_t sdata_tag;
	data_t sdata;
	logic ld_done;
	lsq_ndx_t ld_tag;
	data_t ld_data;
	// Expected load value from the pattern file, travels with the enqueue
	data_t exp_data;

	logic [31:0] pat [PAT_WORDS];
	lsq_ndx_t st_tag [64];
	int n_st;
	int tb_errors;
	int sva_errors;
	bit aborted;
	int err_cnt;
	int done_cnt;
	int pending;

	initial clk = 1'b0;
	always #2 clk = ~clk;

	lsq_top DUT (
		.clk_i(clk), .arst_n_i(arst_n),
		.enq_valid_i(enq_valid), .enq_load_i(enq_load),
		.enq_size_i(enq_size), .enq_addr_i(enq_addr),
		.sdata_valid_i(sdata_valid), .sdata_tag_i(sdata_tag), .sdata_i(sdata),
		.full_o(full), .enq_tag_o(enq_tag),
		.ld_done_o(ld_done), .ld_tag_o(ld_tag), .ld_data_o(ld_data)
	);

	lsq_checker u_checker (
		.clk_i(clk), .arst_n_i(arst_n),
		.enq_valid_i(enq_valid), .enq_load_i(enq_load), .enq_size_i(enq_size),
		.enq_addr_i(enq_addr), .enq_tag_i(enq_tag), .full_i(full), .enq_exp_i(exp_data),
		.sdata_valid_i(sdata_valid), .sdata_tag_i(sdata_tag), .sdata_i(sdata),
		.ld_done_i(ld_done), .ld_tag_i(ld_tag), .ld_data_i(ld_data),
		.err_cnt_o(err_cnt), .done_cnt_o(done_cnt), .pending_o(pending)
	);

	bind lsq_queue lsq_sva u_queue_sva (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .ld_req_i(1'b0), .st_req_i(1'b0),
		.ld_gnt_i(1'b0), .st_gnt_i(1'b0),
		.full_i(full_o), .enq_valid_i(enq_valid_i), .enq_tag_i(enq_tag_o),
		.ld_complete_i(ld_complete_i),
		.ld_complete_tag_i(ld_complete_tag_i), .ent_valid_i(ent_valid_o)
	);

	bind lsq_mem_arbiter lsq_sva u_arbiter_sva (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .ld_req_i(ld_req_i), .st_req_i(st_req_i),
		.ld_gnt_i(ld_gnt_o), .st_gnt_i(st_gnt_o),
		.full_i(1'b0), .enq_valid_i(1'b0), .enq_tag_i('0), .ld_complete_i(1'b0),
		.ld_complete_tag_i('0), .ent_valid_i('0)
	);

	// ==========================================================
	// Driver tasks
	// ==========================================================

	// Inputs change 1 ns after the rising edge, strobes last one cycle
	task automatic next_cycle();
		@(posedge clk);
		#1;
		enq_valid = 1'b0;
		sdata_valid = 1'b0;
	endtask

	task automatic wait_not_full();
		int n;
		n = 0;
		while (full && !aborted) begin
			next_cycle();
			n++;
			if (n > FULL_LIMIT) begin
				$display("Timeout: queue stayed full for %0d cycles", FULL_LIMIT);
				tb_errors++;
				aborted = 1'b1;
			end
		end
	endtask

	// Store tags are kept by store number so that late data can find its entry
	task automatic enqueue(logic is_load, memsz_t sz, word_addr_t addr, data_t expv);
		wait_not_full();
		if (!aborted) begin
			enq_valid = 1'b1;
			enq_load = is_load;
			enq_size = sz;
			enq_addr = addr;
			exp_data = expv;
			if (!is_load && n_st < 64) begin
				st_tag[n_st] = enq_tag;
				n_st++;
			end
		end
	endtask

	initial begin
		int pc;
		int n;
		logic [3:0] op;
		memsz_t size;
		word_addr_t addr;
		data_t val;

		enq_valid = 1'b0;
		enq_load = 1'b0;
		enq_size = '0;
		enq_addr = '0;
		sdata_valid = 1'b0;
		sdata_tag = '0;
		sdata = '0;
		exp_data = '0;
		arst_n = 1'b0;
		tb_errors = 0;
		sva_errors = 0;
		aborted = 1'b0;
		n_st = 0;
		void'($urandom(63881));
		$readmemh("dv/lsq_patterns.txt", pat);

		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;

		pc = 0;
		while (!aborted && pc + 3 < PAT_WORDS && pat[pc][3:0] != 4'hF) begin
			op = pat[pc][3:0];
			size = memsz_t'(pat[pc+1][1:0]);
			addr = pat[pc+2][7:0];
			val = pat[pc+3];
			next_cycle();
			// Occasional random bubbles shift the relative timing of the operations
			if ($urandom % 8 == 0) begin
				repeat (1 + $urandom % 2) next_cycle();
			end
			case (op)
				4'h0: repeat (addr) next_cycle();
				4'h1: enqueue(1'b0, size, addr, '0);
				4'h2: enqueue(1'b1, size, addr, val);
				4'h3: begin
					sdata_valid = 1'b1;
					sdata_tag = st_tag[addr[5:0]];
					sdata = val;
				end
				4'h4: begin
					enqueue(1'b0, size, addr, '0);
					sdata_valid = !aborted;
					sdata_tag = enq_tag;
					sdata = val;
				end
				default: begin
					$display("Unknown pattern operation %h at word %0d", op, pc);
					tb_errors++;
				end
			endcase
			pc += 4;
		end

		// Every load that went in has to come back
		next_cycle();
		n = 0;
		while (!aborted && pending != 0) begin
			next_cycle();
			n++;
			if (n > DRAIN_LIMIT) begin
				$display("Timeout: %0d loads never completed", pending);
				tb_errors++;
				aborted = 1'b1;
			end
		end
		if (done_cnt == 0) begin
			$display("No load results were checked");
			tb_errors++;
		end

		sva_errors = DUT.u_queue.u_queue_sva.fail_cnt + DUT.u_arbiter.u_arbiter_sva.fail_cnt;
		$display("Loads checked: %0d, checker errors: %0d, testbench errors: %0d, %s %0d",
		         done_cnt, err_cnt, tb_errors, "assertion errors:", sva_errors);
		if (err_cnt == 0 && tb_errors == 0 && sva_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== dv/lsq_patterns.txt ====
// Columns: op size addr value, all hex, one operation per line
// op 0 idle (addr = cycles), 1 store, 2 load (value = expected), 3 store data (addr = store number),
// op 4 store with its data in the same cycle, F end of stream

// Forwarding from a single older store
1 2 10 00000000
3 0 00 11223344
2 2 10 11223344

// Two matching stores, the younger one must win
1 2 20 00000000
3 0 01 AAAA0001
1 2 20 00000000
3 0 02 BBBB0002
2 2 20 BBBB0002

// Size mismatch blocks the load until both stores have drained
4 2 30 12345678
4 0 30 FFFFFFEF
2 1 30 000056EF

// Store data arrives well after the dependent load
1 1 40 00000000
2 1 40 0000BEEF
0 0 08 00000000
3 0 05 CAFEBEEF

// Burst that fills the queue with unrelated traffic
4 2 70 70707070
2 2 10 11223344
4 2 71 71717171
2 0 20 00000002
4 2 72 72727272
2 2 80 00000000
4 1 73 73737373
2 2 81 00000000
4 2 74 74747474
2 1 30 000056EF
4 2 75 75757575
2 2 82 00000000
4 2 76 76767676
2 2 83 00000000
4 2 77 77777777
2 2 84 00000000
2 2 70 70707070
2 1 73 00007373
2 2 77 77777777
F 0 00 00000000

// ==== vlog.f ====
verilog/lsq_pkg.sv
verilog/lsq_bypass_index.sv
verilog/lsq_queue.sv
verilog/lsq_load_issue.sv
verilog/lsq_store_drain.sv
verilog/lsq_mem_arbiter.sv
verilog/lsq_data_mem.sv
verilog/lsq_top.sv
dv/lsq_sva.sv
dv/lsq_checker.sv
dv/lsq_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module lsq_tb -f vlog.f -o Vlsq_tb

# An aborted run never reaches the pass line, so both messages are searched
./obj_dir/Vlsq_tb 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log || ! grep -q "=== PASS ===" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation passed"
